/* common/ibypass_config.svh */
// Build-time configuration of the instruction bypass fetch block.
// Widths are powers of two and LINE_WIDTH is a multiple of APB_DW.
// The order FIFO depth limits how many granted lines can be outstanding.
`ifndef IBYPASS_CONFIG_SVH
`define IBYPASS_CONFIG_SVH

// Fetch address width in bits
`define IBYPASS_FETCH_AW 32

// Instruction word width in bits
`define IBYPASS_FETCH_DW 32

// Refill line width in bits
`define IBYPASS_LINE_WIDTH 128

// Number of independent fetch ports
`define IBYPASS_NR_PORTS 2

// Data width of the APB refill bus
`define IBYPASS_APB_DW 32

// Grants the order FIFO can hold
`define IBYPASS_ORDER_DEPTH 4

`endif

/* common/ibypass_pkg.sv */
// Types and derived constants shared by the bypass fetch modules.
// All values follow from the macros in the configuration header.
`default_nettype none

`include "ibypass_config.svh"

package ibypass_pkg;

  // Byte offset bits inside one refill line
  localparam int unsigned LINE_ALIGN = $clog2(`IBYPASS_LINE_WIDTH / 8);
  // Byte offset bits inside one instruction word
  localparam int unsigned FETCH_ALIGN = $clog2(`IBYPASS_FETCH_DW / 8);
  // APB beats needed to assemble one line
  localparam int unsigned BEATS = `IBYPASS_LINE_WIDTH / `IBYPASS_APB_DW;

  typedef logic [`IBYPASS_FETCH_AW-1:0]   fetch_addr_t;
  typedef logic [`IBYPASS_FETCH_DW-1:0]   fetch_data_t;
  typedef logic [`IBYPASS_LINE_WIDTH-1:0] line_t;
  typedef logic [`IBYPASS_NR_PORTS-1:0]   port_mask_t;

  // Per-port request sequence, one fetch at a time
  typedef enum logic [1:0] {
    Idle,
    Request,
    Wait,
    Present
  } port_state_e;

endpackage

`default_nettype wire

/* common/refill_if.sv */
// Line refill channel between the port arbiter and the refill engine.
// Both directions use valid/ready and a raised valid holds its payload.
// Only one line is in flight at a time on this channel.
`default_nettype none

interface refill_if;

  // Request channel carries a line-aligned address
  logic                     req_valid;
  logic                     req_ready;
  ibypass_pkg::fetch_addr_t req_addr;

  // Response channel returns the whole line with one error flag
  logic                     rsp_valid;
  logic                     rsp_ready;
  ibypass_pkg::line_t       rsp_line;
  logic                     rsp_error;

  modport requester (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid,
    input  rsp_line,
    input  rsp_error,
    output rsp_ready
  );

  modport responder (
    input  req_valid,
    input  req_addr,
    output req_ready,
    output rsp_valid,
    output rsp_line,
    output rsp_error,
    input  rsp_ready
  );

endinterface

`default_nettype wire

/* bypass/fetch_port_ctrl.sv */
// Request sequencer for one fetch port.
// Relies on the requester keeping inst_addr_i stable until inst_ready_o.
// Data and error are valid only in the single cycle inst_ready_o is high.
`default_nettype none

`include "ibypass_config.svh"

module fetch_port_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  logic                     inst_valid_i,
  input  ibypass_pkg::fetch_addr_t inst_addr_i,
  output logic                     inst_ready_o,
  output ibypass_pkg::fetch_data_t inst_data_o,
  output logic                     inst_error_o,

  output logic                     req_valid_o,
  input  logic                     req_ready_i,
  input  logic                     rsp_valid_i,
  input  ibypass_pkg::line_t       rsp_line_i,
  input  logic                     rsp_error_i
);

  localparam int unsigned WordIdxW = ibypass_pkg::LINE_ALIGN - ibypass_pkg::FETCH_ALIGN;

  ibypass_pkg::port_state_e state_d, state_q;
  logic [WordIdxW-1:0]      word_idx;

  // Word position of the requested address within its line
  assign word_idx = inst_addr_i[ibypass_pkg::LINE_ALIGN-1:ibypass_pkg::FETCH_ALIGN];

  always_comb begin
    state_d      = state_q;
    req_valid_o  = 1'b0;
    inst_ready_o = 1'b0;
    unique case (state_q)
      ibypass_pkg::Idle: begin
        if (inst_valid_i) begin
          state_d = ibypass_pkg::Request;
        end
      end
      ibypass_pkg::Request: begin
        req_valid_o = 1'b1;
        if (req_ready_i) begin
          state_d = ibypass_pkg::Wait;
        end
      end
      ibypass_pkg::Wait: begin
        if (rsp_valid_i) begin
          state_d = ibypass_pkg::Present;
        end
      end
      ibypass_pkg::Present: begin
        // The registered word is handed over in this one cycle
        inst_ready_o = 1'b1;
        state_d      = ibypass_pkg::Idle;
      end
      default: begin
        state_d = ibypass_pkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ibypass_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture only our word out of the broadcast line
  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      inst_data_o  <= rsp_line_i[word_idx * `IBYPASS_FETCH_DW +: `IBYPASS_FETCH_DW];
      inst_error_o <= rsp_error_i;
    end
  end

  // The arbiter must route a line only to a port that is waiting for one
  a_rsp_only_in_wait : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i |-> state_q == ibypass_pkg::Wait
  );

endmodule

`default_nettype wire

/* bypass/bypass_arbiter.sv */
// Round-robin arbiter feeding one refill channel from all fetch ports.
// Grants are remembered in order, so responses must return in request order.
// No grant is given while ORDER_DEPTH grants are still waiting for a line.
`default_nettype none

`include "ibypass_config.svh"

module bypass_arbiter (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,

  input  ibypass_pkg::port_mask_t                          req_valid_i,
  output ibypass_pkg::port_mask_t                          req_ready_o,
  output ibypass_pkg::port_mask_t                          rsp_valid_o,
  input  ibypass_pkg::fetch_addr_t [`IBYPASS_NR_PORTS-1:0] addr_i,
  output ibypass_pkg::line_t                               rsp_line_o,
  output logic                                             rsp_error_o,

  refill_if.requester                                      refill
);

  localparam int unsigned NrPorts = `IBYPASS_NR_PORTS;
  localparam int unsigned Depth   = `IBYPASS_ORDER_DEPTH;
  localparam int unsigned IdxW    = (NrPorts > 1) ? $clog2(NrPorts) : 1;
  localparam int unsigned PtrW    = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW    = $clog2(Depth + 1);
  localparam ibypass_pkg::fetch_addr_t LineMask =
    ~ibypass_pkg::fetch_addr_t'((2 ** ibypass_pkg::LINE_ALIGN) - 1);

  ibypass_pkg::port_mask_t grant;
  logic [IdxW-1:0]         grant_idx;
  logic [IdxW-1:0]         last_q;
  logic                    can_grant;
  logic                    grant_en;

  logic                     req_pending_q;
  ibypass_pkg::fetch_addr_t req_addr_q;

  ibypass_pkg::port_mask_t order_q [Depth];
  logic [PtrW-1:0]         wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]         count_q;
  logic                    fifo_full, fifo_empty;
  logic                    push, pop;

  // Search starts at the port after the one granted last
  always_comb begin
    int unsigned idx;
    grant     = '0;
    grant_idx = last_q;
    for (int unsigned k = 1; k <= NrPorts; k++) begin
      idx = (last_q + k) % NrPorts;
      if (grant == '0 && req_valid_i[idx]) begin
        grant[idx] = 1'b1;
        grant_idx  = IdxW'(idx);
      end
    end
  end

  assign fifo_full  = (count_q == CntW'(Depth));
  assign fifo_empty = (count_q == '0);

  // The output register must be free or draining this cycle
  assign can_grant   = !fifo_full && (!req_pending_q || refill.req_ready);
  assign grant_en    = can_grant && (|req_valid_i);
  assign req_ready_o = grant & {NrPorts{can_grant}};

  assign push = |req_ready_o;
  assign pop  = refill.rsp_valid;

  assign refill.req_valid = req_pending_q;
  assign refill.req_addr  = req_addr_q;
  assign refill.rsp_ready = 1'b1;

  assign rsp_valid_o = refill.rsp_valid ? order_q[rd_ptr_q] : '0;
  assign rsp_line_o  = refill.rsp_line;
  assign rsp_error_o = refill.rsp_error;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q        <= '0;
      req_pending_q <= 1'b0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
    end else begin
      if (grant_en) begin
        last_q        <= grant_idx;
        req_pending_q <= 1'b1;
      end else if (refill.req_ready) begin
        req_pending_q <= 1'b0;
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_en) begin
      req_addr_q <= addr_i[grant_idx] & LineMask;
    end
    if (push) begin
      order_q[wr_ptr_q] <= grant;
    end
  end

  a_grant_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(req_ready_o) && ((req_ready_o & ~req_valid_i) == '0)
  );

  // The order FIFO never holds more grants than it has entries
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) count_q <= CntW'(Depth)
  );

  // A line returning without an outstanding grant means the refill side misbehaved
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop |-> !fifo_empty
  );

endmodule

`default_nettype wire

/* verilog/apb_refill.sv */
// APB master that reads one line as BEATS consecutive word reads.
// Read-only, with one line in flight, and no timeout on apb_pready_i.
// A slave error on any beat flags the whole line.
`default_nettype none

`include "ibypass_config.svh"

module apb_refill (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  refill_if.responder                 refill,

  output logic                        apb_psel_o,
  output logic                        apb_penable_o,
  output logic                        apb_pwrite_o,
  output ibypass_pkg::fetch_addr_t    apb_paddr_o,
  input  logic [`IBYPASS_APB_DW-1:0]  apb_prdata_i,
  input  logic                        apb_pready_i,
  input  logic                        apb_pslverr_i
);

  localparam int unsigned LineW    = `IBYPASS_LINE_WIDTH;
  localparam int unsigned ApbDw    = `IBYPASS_APB_DW;
  localparam int unsigned ApbAlign = $clog2(ApbDw / 8);
  localparam int unsigned BeatW    = (ibypass_pkg::BEATS > 1) ? $clog2(ibypass_pkg::BEATS) : 1;

  typedef enum logic [1:0] {
    RfIdle,
    RfSetup,
    RfAccess,
    RfDone
  } refill_state_e;

  refill_state_e            state_q;
  logic [BeatW-1:0]         beat_q;
  ibypass_pkg::fetch_addr_t base_q;
  ibypass_pkg::line_t       line_q;
  logic                     err_q;
  logic                     beat_done;
  logic                     last_beat;

  assign beat_done = (state_q == RfAccess) && apb_pready_i;
  assign last_beat = (beat_q == BeatW'(ibypass_pkg::BEATS - 1));

  assign apb_psel_o    = (state_q == RfSetup) || (state_q == RfAccess);
  assign apb_penable_o = (state_q == RfAccess);
  assign apb_pwrite_o  = 1'b0;
  // Beat n reads the word n bus widths above the line base
  assign apb_paddr_o   = base_q + (ibypass_pkg::fetch_addr_t'(beat_q) << ApbAlign);

  assign refill.req_ready = (state_q == RfIdle);
  assign refill.rsp_valid = (state_q == RfDone);
  assign refill.rsp_line  = line_q;
  assign refill.rsp_error = err_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RfIdle;
      beat_q  <= '0;
    end else begin
      unique case (state_q)
        RfIdle: begin
          if (refill.req_valid) begin
            state_q <= RfSetup;
            beat_q  <= '0;
          end
        end
        RfSetup: begin
          state_q <= RfAccess;
        end
        RfAccess: begin
          if (apb_pready_i) begin
            state_q <= last_beat ? RfDone : RfSetup;
            beat_q  <= beat_q + 1'b1;
          end
        end
        RfDone: begin
          if (refill.rsp_ready) begin
            state_q <= RfIdle;
          end
        end
        default: begin
          state_q <= RfIdle;
        end
      endcase
    end
  end

  // Beats shift in from the top so beat 0 ends in the lowest bits
  always_ff @(posedge clk_i) begin
    if (refill.req_valid && refill.req_ready) begin
      base_q <= refill.req_addr;
      err_q  <= 1'b0;
    end else if (beat_done) begin
      line_q <= {apb_prdata_i, line_q[LineW-1:ApbDw]};
      err_q  <= err_q | apb_pslverr_i;
    end
  end

  a_apb_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (apb_penable_o && !apb_pready_i) |=> ($stable(apb_paddr_o) && apb_psel_o)
  );

endmodule

`default_nettype wire

/* verilog/ibypass_top.sv */
// Uncached instruction fetch block with an APB master for line refills.
// A requester holds valid and address stable until inst_ready_o pulses.
// The APB side is read-only and serves one line at a time.
`default_nettype none

`include "ibypass_config.svh"

module ibypass_top (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,

  input  ibypass_pkg::port_mask_t                             inst_valid_i,
  input  ibypass_pkg::fetch_addr_t [`IBYPASS_NR_PORTS-1:0]    inst_addr_i,
  output ibypass_pkg::port_mask_t                             inst_ready_o,
  output ibypass_pkg::fetch_data_t [`IBYPASS_NR_PORTS-1:0]    inst_data_o,
  output ibypass_pkg::port_mask_t                             inst_error_o,

  output logic                                                apb_psel_o,
  output logic                                                apb_penable_o,
  output logic                                                apb_pwrite_o,
  output ibypass_pkg::fetch_addr_t                            apb_paddr_o,
  input  logic [`IBYPASS_APB_DW-1:0]                          apb_prdata_i,
  input  logic                                                apb_pready_i,
  input  logic                                                apb_pslverr_i
);

  ibypass_pkg::port_mask_t req_valid;
  ibypass_pkg::port_mask_t req_ready;
  ibypass_pkg::port_mask_t rsp_valid;
  ibypass_pkg::line_t      rsp_line;
  logic                    rsp_error;

  refill_if refill_bus ();

  for (genvar i = 0; i < `IBYPASS_NR_PORTS; i++) begin : gen_port
    fetch_port_ctrl i_fetch_port_ctrl (
      .clk_i        ( clk_i           ),
      .arst_n_i     ( arst_n_i        ),
      .inst_valid_i ( inst_valid_i[i] ),
      .inst_addr_i  ( inst_addr_i[i]  ),
      .inst_ready_o ( inst_ready_o[i] ),
      .inst_data_o  ( inst_data_o[i]  ),
      .inst_error_o ( inst_error_o[i] ),
      .req_valid_o  ( req_valid[i]    ),
      .req_ready_i  ( req_ready[i]    ),
      .rsp_valid_i  ( rsp_valid[i]    ),
      .rsp_line_i   ( rsp_line        ),
      .rsp_error_i  ( rsp_error       )
    );
  end

  bypass_arbiter i_bypass_arbiter (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .req_valid_i ( req_valid   ),
    .req_ready_o ( req_ready   ),
    .rsp_valid_o ( rsp_valid   ),
    .addr_i      ( inst_addr_i ),
    .rsp_line_o  ( rsp_line    ),
    .rsp_error_o ( rsp_error   ),
    .refill      ( refill_bus  )
  );

  apb_refill i_apb_refill (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .refill        ( refill_bus    ),
    .apb_psel_o    ( apb_psel_o    ),
    .apb_penable_o ( apb_penable_o ),
    .apb_pwrite_o  ( apb_pwrite_o  ),
    .apb_paddr_o   ( apb_paddr_o   ),
    .apb_prdata_i  ( apb_prdata_i  ),
    .apb_pready_i  ( apb_pready_i  ),
    .apb_pslverr_i ( apb_pslverr_i )
  );

endmodule

`default_nettype wire

/* sim/apb_mem_model.sv */
// APB read slave used as refill memory in simulation only.
// Read data is the byte address XOR 32'h5a5a_0000, bit 31 set gives a slave error.
// Each transfer gets 0 to 3 wait states drawn from $random with the given seed.
`default_nettype none

`include "ibypass_config.svh"

module apb_mem_model #(
  parameter logic [31:0] SEED = 32'h0
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  ibypass_pkg::fetch_addr_t   paddr_i,
  output logic [`IBYPASS_APB_DW-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o
);

  integer     seed;
  logic [1:0] wait_q;

  initial begin
    seed = SEED;
  end

  // A new wait count is drawn in every setup phase
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= '0;
    end else if (psel_i && !penable_i) begin
      wait_q <= 2'($random(seed));
    end else if (psel_i && penable_i && wait_q != '0) begin
      wait_q <= wait_q - 1'b1;
    end
  end

  assign pready_o  = psel_i && penable_i && (wait_q == '0);
  assign prdata_o  = paddr_i ^ 32'h5a5a_0000;
  assign pslverr_o = pready_o && paddr_i[31];

endmodule

`default_nettype wire

/* sim/tb_ibypass.sv */
// Testbench for ibypass_top with an APB memory model as refill slave.
// All fetch addresses are word aligned, so each expected word follows from its address.
// Data and error flags follow the memory model's address rule.
`default_nettype none

`include "ibypass_config.svh"

module tb_ibypass;

  localparam int unsigned NrPorts  = `IBYPASS_NR_PORTS;
  localparam int unsigned ConcRuns = 8;
  localparam int unsigned WaitRuns = 8;
  localparam int unsigned NrFetch  = 1 + 4 + 2 * ConcRuns + 2 + WaitRuns;
  localparam int unsigned Limit    = 200 * NrFetch + 100;
  localparam logic [31:0] Seed     = 32'h84ed86ae;
  localparam logic [31:0] DataKey  = 32'h5a5a_0000;
  localparam ibypass_pkg::fetch_addr_t OffMask = (1 << ibypass_pkg::LINE_ALIGN) - 1;

  logic                                   clk;
  logic                                   arst_n;
  ibypass_pkg::port_mask_t                inst_valid;
  ibypass_pkg::fetch_addr_t [NrPorts-1:0] inst_addr;
  ibypass_pkg::port_mask_t                inst_ready;
  ibypass_pkg::fetch_data_t [NrPorts-1:0] inst_data;
  ibypass_pkg::port_mask_t                inst_error;
  logic                                   psel, penable, pwrite, pready, pslverr;
  ibypass_pkg::fetch_addr_t               paddr, apb_base, apb_expect;
  logic [`IBYPASS_APB_DW-1:0]             prdata;
  int unsigned                            apb_beat;
  integer                                 seed;
  string                                  test_name;
  int unsigned                            errors, errors_base, fetches, tests;

  ibypass_top DUT (
    .clk_i (clk), .arst_n_i (arst_n),
    .inst_valid_i (inst_valid), .inst_addr_i (inst_addr), .inst_ready_o (inst_ready),
    .inst_data_o (inst_data), .inst_error_o (inst_error),
    .apb_psel_o (psel), .apb_penable_o (penable), .apb_pwrite_o (pwrite),
    .apb_paddr_o (paddr), .apb_prdata_i (prdata), .apb_pready_i (pready),
    .apb_pslverr_i (pslverr)
  );

  apb_mem_model #(.SEED (Seed)) i_apb_mem_model (
    .clk_i (clk), .arst_n_i (arst_n), .psel_i (psel), .penable_i (penable),
    .paddr_i (paddr), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  // The memory returns each word address XOR the key
  function automatic ibypass_pkg::fetch_data_t expected_word(input ibypass_pkg::fetch_addr_t a);
    return (a & 32'hffff_fffc) ^ DataKey;
  endfunction

  // True when the line address belongs to a fetch that is still waiting
  function automatic logic line_pending(input ibypass_pkg::fetch_addr_t a,
                                        input ibypass_pkg::port_mask_t v,
                                        input ibypass_pkg::fetch_addr_t [NrPorts-1:0] addrs);
    logic hit;
    hit = 1'b0;
    for (int unsigned p = 0; p < NrPorts; p++) begin
      if (v[p] && a == (addrs[p] & ~OffMask)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic ibypass_pkg::fetch_addr_t random_word_addr(input logic allow_err);
    ibypass_pkg::fetch_addr_t a;
    a      = $random(seed);
    a[1:0] = 2'b00;
    if (!allow_err) begin
      a[31] = 1'b0;
    end
    return a;
  endfunction

  task automatic fetch(input int unsigned p, input ibypass_pkg::fetch_addr_t a);
    @(posedge clk);
    inst_valid[p] <= 1'b1;
    inst_addr[p]  <= a;
    @(posedge clk);
    while (!inst_ready[p]) @(posedge clk);
    inst_valid[p] <= 1'b0;
    fetches++;
  endtask

  // One more edge lets the checks of the last fetch report first
  task automatic finish_test();
    @(posedge clk);
    $display("%s finished with %0d errors", test_name, errors - errors_base);
    errors_base = errors;
    tests++;
  endtask

  // Beat position and line base of the APB reads seen so far
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      apb_beat <= 0;
      apb_base <= '0;
    end else if (psel && penable && pready) begin
      if (apb_beat == 0) begin
        apb_base <= paddr & ~OffMask;
      end
      apb_beat <= (apb_beat == ibypass_pkg::BEATS - 1) ? 0 : apb_beat + 1;
    end
  end

  assign apb_expect = apb_base + ibypass_pkg::fetch_addr_t'(4 * apb_beat);

  a_reset_quiet : assert property (@(posedge clk) $past(!arst_n) |->
    (inst_ready == '0 && !psel && !penable))
    else begin
      $display("error %s: expected ready/psel/penable 0/0/0 actual %b/%b/%b", test_name,
               $sampled(inst_ready), $sampled(psel), $sampled(penable));
      errors++;
    end

  a_read_only : assert property (@(posedge clk) disable iff (!arst_n) !pwrite)
    else begin
      $display("%s: the APB master issued a write", test_name);
      errors++;
    end

  a_line_base : assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !penable && apb_beat == 0) |-> line_pending(paddr, inst_valid, inst_addr))
    else begin
      $display("%s: APB line address %h belongs to no pending fetch", test_name,
               $sampled(paddr));
      errors++;
    end

  a_beat_addr : assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !penable && apb_beat != 0) |-> paddr == apb_expect)
    else begin
      $display("error %s apb address: expected %h actual %h", test_name,
               $sampled(apb_expect), $sampled(paddr));
      errors++;
    end

  a_wait_hold : assert property (@(posedge clk) disable iff (!arst_n)
    (psel && penable && !pready) |=> (psel && penable && $stable(paddr)))
    else begin
      $display("%s: APB address or select changed during a wait state", test_name);
      errors++;
    end

  for (genvar p = 0; p < NrPorts; p++) begin : gen_check
    a_word : assert property (@(posedge clk) disable iff (!arst_n)
      inst_ready[p] |-> inst_data[p] == expected_word(inst_addr[p]))
      else begin
        $display("error %s port %0d data: expected %h actual %h", test_name, p,
                 expected_word($sampled(inst_addr[p])), $sampled(inst_data[p]));
        errors++;
      end

    a_flag : assert property (@(posedge clk) disable iff (!arst_n)
      inst_ready[p] |-> inst_error[p] == inst_addr[p][31])
      else begin
        $display("error %s port %0d error flag: expected %b actual %b", test_name, p,
                 $sampled(inst_addr[p][31]), $sampled(inst_error[p]));
        errors++;
      end

    a_ready_needs_valid : assert property (@(posedge clk) disable iff (!arst_n)
      inst_ready[p] |-> inst_valid[p])
      else begin
        $display("%s: port %0d signalled ready without a pending fetch", test_name, p);
        errors++;
      end
  end

  // Watchdog sized from the number of fetches the tests issue
  initial begin
    repeat (Limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", Limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    ibypass_pkg::fetch_addr_t a0, a1;
    seed        = Seed;
    errors      = 0;
    errors_base = 0;
    fetches     = 0;
    tests       = 0;
    test_name   = "reset";
    inst_valid  = '0;
    inst_addr   = '0;
    arst_n      = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    finish_test();

    test_name = "single_fetch";
    fetch(1, 32'h0000_0104);
    finish_test();

    test_name = "word_select";
    for (int unsigned w = 0; w < 4; w++) begin
      fetch(0, 32'h0000_2340 + 4 * w);
    end
    finish_test();

    test_name = "concurrent";
    for (int unsigned i = 0; i < ConcRuns; i++) begin
      a0 = random_word_addr(1'b1);
      a1 = random_word_addr(1'b1);
      fork
        fetch(0, a0);
        fetch(1, a1);
      join
    end
    finish_test();

    test_name = "error";
    fetch(0, 32'h8000_0a28);
    fetch(0, 32'h0000_0a28);
    finish_test();

    test_name = "wait_states";
    for (int unsigned i = 0; i < WaitRuns; i++) begin
      repeat ($random(seed) & 3) @(posedge clk);
      fetch(1, random_word_addr(1'b0));
    end
    finish_test();

    $display("%0d tests, %0d fetches, %0d errors", tests, fetches, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/ibypass_pkg.sv
common/refill_if.sv
bypass/fetch_port_ctrl.sv
bypass/bypass_arbiter.sv
verilog/apb_refill.sv
verilog/ibypass_top.sv
sim/apb_mem_model.sv
sim/tb_ibypass.sv

/* Bender.yml */
package:
  name: ibypass

sources:
  - include_dirs:
      - common
    files:
      - common/ibypass_pkg.sv
      - common/refill_if.sv
      - bypass/fetch_port_ctrl.sv
      - bypass/bypass_arbiter.sv
      - verilog/apb_refill.sv
      - verilog/ibypass_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/apb_mem_model.sv
      - sim/tb_ibypass.sv
